// File: Makefile
TOP = tb_rv_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

// File: project.f
rtl/rv_core_pkg.sv
rtl/rv_regfile.sv
rtl/rv_int_exec.sv
rtl/rv_csr_trap.sv
rtl/rv_retire.sv
rtl/rv_core_top.sv
sim/tb_rv_core.sv

// File: rtl/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN     = 64;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] xlen_t;     // Register or PC value
    typedef logic [31:0]     inst_t;     // Raw instruction word
    typedef logic [4:0]      reg_idx_t;  // rs1, rs2, rd
    typedef logic [11:0]     csr_addr_t; // ir[31:20] of CSR ops

    // Major opcodes in ir[6:0]
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_W = 7'b0011011; // ADDIW, SLLIW, SRLIW, SRAIW
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP_W     = 7'b0111011; // ADDW ... SRAW
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011; // CSR ops and MRET

    localparam logic [2:0] F3_ADD_SUB = 3'b000; // SUB when ir[30] set on OP
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // SRA when ir[30] set
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101; // Immediate forms use zimm in ir[19:15]
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    // Machine CSRs kept in this core
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    localparam logic [11:0] MRET_FUNCT12 = 12'h302;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    localparam xlen_t MCAUSE_MEXT_IRQ = 64'h8000_0000_0000_000B; // Interrupt, cause 11
    localparam xlen_t RESET_PC        = 64'd0;
    localparam inst_t NOP_INST        = 32'h0000_0013; // ADDI x0, x0, 0

endpackage

// File: rtl/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic               clk,
    input  logic               reset,
    input  rv_core_pkg::inst_t instruction_i, // Word at pc_o, same cycle
    input  logic               interrupt_i,
    output rv_core_pkg::xlen_t pc_o,
    output logic               interrupt_ack_o,
    output rv_core_pkg::xlen_t regs_o [rv_core_pkg::NUM_REGS]
);
    import rv_core_pkg::*;

    inst_t    ir;
    logic     valid;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    logic     wr_en;
    reg_idx_t wr_idx;
    xlen_t    wr_data;
    xlen_t    int_result;
    logic     int_wr_en;
    logic     jump_taken;
    xlen_t    jump_target;
    xlen_t    csr_result;
    logic     csr_wr_en;
    logic     redirect;
    xlen_t    redirect_pc;

    // IR, PC and write-back merge
    rv_retire u_retire (
        .clk(clk), .reset(reset), .instruction_i(instruction_i),
        .int_result_i(int_result), .int_wr_en_i(int_wr_en),
        .jump_taken_i(jump_taken), .jump_target_i(jump_target),
        .csr_result_i(csr_result), .csr_wr_en_i(csr_wr_en),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .ir_o(ir), .valid_o(valid), .pc_o(pc_o),
        .wr_en_o(wr_en), .wr_idx_o(wr_idx), .wr_data_o(wr_data)
    );

    rv_regfile u_regfile (
        .clk(clk), .reset(reset),
        .rs1_idx_i(ir[19:15]), .rs2_idx_i(ir[24:20]), // Read straight from IR fields
        .wr_en_i(wr_en), .wr_idx_i(wr_idx), .wr_data_i(wr_data),
        .rs1_val_o(rs1_val), .rs2_val_o(rs2_val), .regs_o(regs_o)
    );

    rv_int_exec u_int_exec (
        .ir_i(ir), .pc_i(pc_o), .rs1_val_i(rs1_val), .rs2_val_i(rs2_val),
        .result_o(int_result), .wr_en_o(int_wr_en),
        .jump_taken_o(jump_taken), .jump_target_o(jump_target)
    );

    // Side by side with the integer unit
    rv_csr_trap u_csr_trap (
        .clk(clk), .reset(reset), .ir_i(ir), .valid_i(valid),
        .rs1_val_i(rs1_val), .pc_i(pc_o), .interrupt_i(interrupt_i),
        .result_o(csr_result), .wr_en_o(csr_wr_en),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .interrupt_ack_o(interrupt_ack_o)
    );

endmodule

// File: rtl/rv_csr_trap.sv
`timescale 1ns/1ps

module rv_csr_trap (
    input  logic               clk,
    input  logic               reset,
    input  rv_core_pkg::inst_t ir_i,
    input  logic               valid_i,
    input  rv_core_pkg::xlen_t rs1_val_i,
    input  rv_core_pkg::xlen_t pc_i,
    input  logic               interrupt_i,     // Level, held until ack
    output rv_core_pkg::xlen_t result_o,
    output logic               wr_en_o,
    output logic               redirect_o,
    output rv_core_pkg::xlen_t redirect_pc_o,
    output logic               interrupt_ack_o
);
    import rv_core_pkg::*;

    logic [2:0] funct3;
    logic [4:0] src_idx;  // rs1 index or zimm, same field
    logic       is_csr;
    logic       is_mret;
    logic       csr_we;
    logic       take_irq;
    csr_addr_t  csr_addr;
    xlen_t      operand;
    xlen_t      old_val;
    xlen_t      new_val;
    xlen_t      mstatus;
    xlen_t      mtvec;
    xlen_t      mscratch;
    xlen_t      mepc;
    xlen_t      mcause;

    assign funct3   = ir_i[14:12];
    assign src_idx  = ir_i[19:15];
    assign csr_addr = ir_i[31:20];
    assign operand  = funct3[2] ? {59'd0, src_idx} : rs1_val_i; // Immediate forms take zimm
    assign is_mret  = (ir_i[6:0] == OPC_SYSTEM) && (ir_i[31:7] == {MRET_FUNCT12, 13'd0});
    assign take_irq = valid_i && interrupt_i && mstatus[MSTATUS_MIE_BIT]; // Never in a bubble

    always_comb begin
        case (csr_addr)
            CSR_MSTATUS:  old_val = mstatus;
            CSR_MTVEC:    old_val = mtvec;
            CSR_MSCRATCH: old_val = mscratch;
            CSR_MEPC:     old_val = mepc;
            CSR_MCAUSE:   old_val = mcause;
            default:      old_val = '0; // Unmapped reads zero
        endcase
    end

    always_comb begin
        is_csr  = ir_i[6:0] == OPC_SYSTEM;
        new_val = old_val;
        csr_we  = 1'b0;
        case (funct3)
            F3_CSRRW, F3_CSRRWI: begin
                new_val = operand;
                csr_we  = 1'b1;
            end
            F3_CSRRS, F3_CSRRSI: begin
                new_val = old_val | operand;
                csr_we  = src_idx != 5'd0; // x0 or zimm 0 only reads
            end
            F3_CSRRC, F3_CSRRCI: begin
                new_val = old_val & ~operand;
                csr_we  = src_idx != 5'd0;
            end
            default: is_csr = 1'b0;        // MRET and other privileged ops
        endcase
        csr_we = csr_we && is_csr;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus         <= xlen_t'(1) << MSTATUS_MIE_BIT; // Interrupts on out of reset
            mtvec           <= '0;
            mscratch        <= '0;
            mepc            <= '0;
            mcause          <= '0;
            interrupt_ack_o <= 1'b0;
        end else begin
            interrupt_ack_o <= take_irq; // One cycle, MIE drops with it
            if (take_irq) begin
                mepc                      <= pc_i - 64'd4; // Skipped instruction reruns
                mcause                    <= MCAUSE_MEXT_IRQ;
                mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
                mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
            end else if (valid_i && is_mret) begin
                mstatus[MSTATUS_MIE_BIT]  <= mstatus[MSTATUS_MPIE_BIT];
                mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
            end else if (valid_i && csr_we) begin
                case (csr_addr)
                    CSR_MSTATUS:  mstatus  <= new_val;
                    CSR_MTVEC:    mtvec    <= new_val;
                    CSR_MSCRATCH: mscratch <= new_val;
                    CSR_MEPC:     mepc     <= new_val;
                    CSR_MCAUSE:   mcause   <= new_val;
                    default: ;             // Writes to unmapped addresses dropped
                endcase
            end
        end
    end

    assign result_o      = old_val; // Old value goes to rd
    assign wr_en_o       = is_csr;
    assign redirect_o    = take_irq || (valid_i && is_mret);
    assign redirect_pc_o = take_irq ? mtvec : mepc;

endmodule

// File: rtl/rv_int_exec.sv
`timescale 1ns/1ps

module rv_int_exec (
    input  rv_core_pkg::inst_t ir_i,
    input  rv_core_pkg::xlen_t pc_i,       // Fetch PC, one word ahead of IR
    input  rv_core_pkg::xlen_t rs1_val_i,
    input  rv_core_pkg::xlen_t rs2_val_i,
    output rv_core_pkg::xlen_t result_o,
    output logic               wr_en_o,
    output logic               jump_taken_o,
    output rv_core_pkg::xlen_t jump_target_o
);
    import rv_core_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        is_reg;    // OP or OP_W, second operand from rs2
    logic        is_sub;
    logic        word_ok;   // Legal funct3 for the W group
    logic        br_cond;
    logic [5:0]  shamt;
    logic [31:0] word_sra;
    logic [31:0] word_res;
    xlen_t       inst_pc;
    xlen_t       imm_i;
    xlen_t       imm_u;
    xlen_t       imm_j;
    xlen_t       imm_b;
    xlen_t       op_b;
    xlen_t       sra_res;
    xlen_t       alu_res;

    assign opcode  = ir_i[6:0];
    assign funct3  = ir_i[14:12];
    assign inst_pc = pc_i - 64'd4; // Address of the word in the IR

    assign imm_i = {{52{ir_i[31]}}, ir_i[31:20]};
    assign imm_u = {{32{ir_i[31]}}, ir_i[31:12], 12'd0};
    assign imm_j = {{43{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
    assign imm_b = {{51{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};

    assign is_reg  = (opcode == OPC_OP) || (opcode == OPC_OP_W);
    assign is_sub  = is_reg && ir_i[30];
    assign op_b    = is_reg ? rs2_val_i : imm_i;
    assign shamt   = op_b[5:0];                  // imm_i[5:0] is ir[25:20]
    assign sra_res = $signed(rs1_val_i) >>> shamt;
    assign word_sra = $signed(rs1_val_i[31:0]) >>> shamt[4:0];
    assign word_ok = (funct3 == F3_ADD_SUB) || (funct3 == F3_SLL) || (funct3 == F3_SR);

    // 64-bit ALU shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            F3_ADD_SUB: alu_res = is_sub ? rs1_val_i - op_b : rs1_val_i + op_b;
            F3_SLL:     alu_res = rs1_val_i << shamt;
            F3_SLT:     alu_res = {63'd0, $signed(rs1_val_i) < $signed(op_b)};
            F3_SLTU:    alu_res = {63'd0, rs1_val_i < op_b};
            F3_XOR:     alu_res = rs1_val_i ^ op_b;
            F3_SR:      alu_res = ir_i[30] ? sra_res : rs1_val_i >> shamt;
            F3_OR:      alu_res = rs1_val_i | op_b;
            F3_AND:     alu_res = rs1_val_i & op_b;
            default:    alu_res = '0;
        endcase
    end

    // 32-bit word ops, sign extended below
    always_comb begin
        case (funct3)
            F3_SLL:  word_res = rs1_val_i[31:0] << shamt[4:0];
            F3_SR:   word_res = ir_i[30] ? word_sra : rs1_val_i[31:0] >> shamt[4:0];
            default: word_res = is_sub ? rs1_val_i[31:0] - op_b[31:0]
                                       : rs1_val_i[31:0] + op_b[31:0];
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  br_cond = rs1_val_i == rs2_val_i;
            F3_BNE:  br_cond = rs1_val_i != rs2_val_i;
            F3_BLT:  br_cond = $signed(rs1_val_i) < $signed(rs2_val_i);
            F3_BGE:  br_cond = $signed(rs1_val_i) >= $signed(rs2_val_i);
            F3_BLTU: br_cond = rs1_val_i < rs2_val_i;
            F3_BGEU: br_cond = rs1_val_i >= rs2_val_i;
            default: br_cond = 1'b0; // 010 and 011 undefined
        endcase
    end

    always_comb begin
        result_o      = alu_res;
        wr_en_o       = 1'b0;
        jump_taken_o  = 1'b0;
        jump_target_o = inst_pc + imm_b;
        case (opcode)
            OPC_LUI: begin
                result_o = imm_u;
                wr_en_o  = 1'b1;
            end
            OPC_AUIPC: begin
                result_o = inst_pc + imm_u;
                wr_en_o  = 1'b1;
            end
            OPC_OP_IMM, OPC_OP: wr_en_o = 1'b1;
            OPC_OP_IMM_W, OPC_OP_W: begin
                result_o = {{32{word_res[31]}}, word_res};
                wr_en_o  = word_ok;
            end
            OPC_JAL: begin
                result_o      = pc_i; // Link is instruction address plus 4
                wr_en_o       = 1'b1;
                jump_taken_o  = 1'b1;
                jump_target_o = inst_pc + imm_j;
            end
            OPC_JALR: begin
                result_o      = pc_i;
                wr_en_o       = 1'b1;
                jump_taken_o  = 1'b1;
                jump_target_o = (rs1_val_i + imm_i) & ~64'd1;
            end
            OPC_BRANCH: jump_taken_o = br_cond;
            default: ;               // Anything else retires as a no-op
        endcase
    end

endmodule

// File: rtl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::reg_idx_t rs1_idx_i,
    input  rv_core_pkg::reg_idx_t rs2_idx_i,
    input  logic                  wr_en_i,
    input  rv_core_pkg::reg_idx_t wr_idx_i,
    input  rv_core_pkg::xlen_t    wr_data_i,
    output rv_core_pkg::xlen_t    rs1_val_o,
    output rv_core_pkg::xlen_t    rs2_val_o,
    output rv_core_pkg::xlen_t    regs_o [rv_core_pkg::NUM_REGS]
);
    import rv_core_pkg::*;

    xlen_t regs [NUM_REGS]; // x0 never written, so stays zero

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_idx_i != 5'd0)) begin
            regs[wr_idx_i] <= wr_data_i; // Lands at retire edge
        end
    end

    assign rs1_val_o = regs[rs1_idx_i]; // Async read ports
    assign rs2_val_o = regs[rs2_idx_i];
    assign regs_o    = regs;

endmodule

// File: rtl/rv_retire.sv
`timescale 1ns/1ps

module rv_retire (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::inst_t    instruction_i,
    input  rv_core_pkg::xlen_t    int_result_i,
    input  logic                  int_wr_en_i,
    input  logic                  jump_taken_i,
    input  rv_core_pkg::xlen_t    jump_target_i,
    input  rv_core_pkg::xlen_t    csr_result_i,
    input  logic                  csr_wr_en_i,
    input  logic                  redirect_i,     // Trap entry or MRET
    input  rv_core_pkg::xlen_t    redirect_pc_i,
    output rv_core_pkg::inst_t    ir_o,
    output logic                  valid_o,        // Low in a bubble cycle
    output rv_core_pkg::xlen_t    pc_o,
    output logic                  wr_en_o,
    output rv_core_pkg::reg_idx_t wr_idx_o,
    output rv_core_pkg::xlen_t    wr_data_o
);
    import rv_core_pkg::*;

    logic  jump;     // Branch or jump from a live IR
    logic  flush;    // Any redirect, next IR is stale
    xlen_t next_pc;

    assign jump  = valid_o && jump_taken_i;
    assign flush = redirect_i || jump;

    // Trap or MRET wins over a jump in the same slot
    always_comb begin
        if (redirect_i) begin
            next_pc = redirect_pc_i;
        end else if (jump) begin
            next_pc = jump_target_i;
        end else begin
            next_pc = pc_o + 64'd4;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_o    <= RESET_PC;
            ir_o    <= NOP_INST;
            valid_o <= 1'b0;    // First cycle is a bubble
        end else begin
            pc_o    <= next_pc;
            ir_o    <= instruction_i; // Word fetched at pc_o this cycle
            valid_o <= !flush;
        end
    end

    assign wr_en_o   = valid_o && !redirect_i && (int_wr_en_i || csr_wr_en_i);
    assign wr_idx_o  = ir_o[11:7];
    assign wr_data_o = csr_wr_en_i ? csr_result_i : int_result_i; // CSR read overrides

endmodule

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int LOOP_N       = 30; // Iterations of the interrupt loop

    logic  clk;
    logic  reset;
    inst_t instruction_i;
    logic  interrupt_i;
    xlen_t pc_o;
    logic  interrupt_ack_o;
    xlen_t regs_o [NUM_REGS];

    inst_t imem [256];
    xlen_t exp_reg [NUM_REGS];      // Expected register file
    xlen_t exp_snap [4][NUM_REGS];  // Expected register file at each section end
    xlen_t tgt [xlen_t];            // Expected pc_o after a taken redirect, keyed by its address
    xlen_t pc_prev;
    logic  ack_prev;
    int    wp      = 0;
    int    next_rd = 3;
    int    errors  = 0;
    int    checks  = 0;
    int    cycles  = 0;
    int    limit   = 0;

    rv_core_top uut (
        .clk(clk), .reset(reset), .instruction_i(instruction_i),
        .interrupt_i(interrupt_i), .pc_o(pc_o),
        .interrupt_ack_o(interrupt_ack_o), .regs_o(regs_o)
    );

    always #2 clk = ~clk;

    always @(negedge clk) instruction_i <= imem[pc_o[9:2]]; // Word at pc_o, same cycle

    function automatic xlen_t sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    // RV64 result rules, alt selects SUB or SRA
    function automatic xlen_t model(input logic [6:0] op, input logic [2:0] f3,
                                    input logic alt, input xlen_t a, input xlen_t b);
        logic [31:0] w;
        xlen_t       r;
        if (op == OPC_OP_W || op == OPC_OP_IMM_W) begin
            w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
            if (f3 == F3_SLL) w = a[31:0] << b[4:0];
            if (f3 == F3_SR && alt) w = $signed(a[31:0]) >>> b[4:0];
            if (f3 == F3_SR && !alt) w = a[31:0] >> b[4:0];
            return {{32{w[31]}}, w}; // Word results sign-extend from bit 31
        end
        case (f3)
            F3_ADD_SUB: r = alt ? a - b : a + b;
            F3_SLL:     r = a << b[5:0];
            F3_SLT:     r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            F3_SLTU:    r = (a < b) ? 64'd1 : 64'd0;
            F3_XOR:     r = a ^ b;
            F3_OR:      r = a | b;
            F3_AND:     r = a & b;
            default:    r = a >> b[5:0];
        endcase
        if (f3 == F3_SR && alt) r = $signed(a) >>> b[5:0];
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic inst_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t enc_b(input logic [12:0] o, input reg_idx_t rs2, input reg_idx_t rs1,
                                    input logic [2:0] f3);
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], OPC_BRANCH};
    endfunction

    function automatic inst_t enc_j(input logic [20:0] o, input reg_idx_t rd);
        return {o[20], o[10:1], o[11], o[19:12], rd, OPC_JAL};
    endfunction

    function automatic xlen_t cur_pc();
        return xlen_t'(wp) * 64'd4;
    endfunction

    task automatic emit(input inst_t w);
        imem[wp] = w;
        wp++;
    endtask

    task automatic op_r(input logic [6:0] f7, input logic [2:0] f3, input logic [6:0] op);
        emit(enc_r(f7, 5'd2, 5'd1, f3, 5'(next_rd), op));
        exp_reg[next_rd] = model(op, f3, f7[5], exp_reg[1], exp_reg[2]);
        next_rd++;
    endtask

    task automatic op_i(input logic [11:0] imm, input logic [2:0] f3, input logic [6:0] op);
        emit(enc_i(imm, 5'd1, f3, 5'(next_rd), op));
        exp_reg[next_rd] = model(op, f3, (f3 == F3_SR) && imm[10], exp_reg[1], sext12(imm));
        next_rd++;
    endtask

    // Marker in the slot after a branch, counts in x31 only if executed
    task automatic branch(input logic [2:0] f3, input reg_idx_t rs2);
        xlen_t a;
        logic  t;
        a = cur_pc();
        t = branch_taken(f3, exp_reg[1], exp_reg[rs2]);
        emit(enc_b(13'd8, rs2, 5'd1, f3));
        if (t) tgt[a] = a + 64'd8;
        emit(enc_i(12'd1, 5'd31, F3_ADD_SUB, 5'd31, OPC_OP_IMM));
        if (!t) exp_reg[31] = exp_reg[31] + 64'd1;
    endtask

    task automatic section_end(output xlen_t cp);
        emit(NOP_INST);
        cp = cur_pc();  // pc_o here means the section has retired
        emit(NOP_INST);
    endtask

    task automatic save_expected(input int s);
        for (int i = 0; i < NUM_REGS; i++) begin
            exp_snap[s][i] = exp_reg[i];
        end
    endtask

    task automatic check_value(input string name, input xlen_t got, input xlen_t expv);
        checks++;
        assert (got === expv) else begin
            errors++;
            $display("ERROR %s got 0x%h expected 0x%h", name, got, expv);
        end
    endtask

    task automatic check_regs(input int s);
        for (int i = 0; i < NUM_REGS; i++) begin
            check_value($sformatf("regs_o[%0d]", i), regs_o[i], exp_snap[s][i]);
        end
    endtask

    task automatic check_reset();
        check_value("pc_o", pc_o, RESET_PC);
        check_value("interrupt_ack_o", xlen_t'(interrupt_ack_o), 64'd0);
        for (int i = 0; i < NUM_REGS; i++) begin
            check_value($sformatf("regs_o[%0d]", i), regs_o[i], 64'd0);
        end
    endtask

    task automatic wait_pc(input xlen_t target);
        while (pc_o !== target) @(negedge clk);
    endtask

    // Redirect targets and one-cycle ack pulse
    always @(negedge clk) begin
        if (reset && tgt.exists(pc_prev - 64'd4)) begin
            check_value("pc_o", pc_o, tgt[pc_prev - 64'd4]);
        end
        if (reset) begin
            assert (!(ack_prev && interrupt_ack_o)) else begin
                errors++;
                $display("interrupt_ack_o stayed high for more than one cycle");
            end
        end
        pc_prev  <= pc_o;
        ack_prev <= interrupt_ack_o;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Run stopped after %0d cycles without reaching the end", cycles);
            $display("Checks: %0d  errors: %0d", checks, errors + 1);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        logic [19:0] hi;
        logic [11:0] lo;
        logic [2:0]  bf [6];
        logic [4:0]  z1, z2, z3;
        xlen_t       cp_a, cp_b, cp_c, p, ms, tv, hnd_pc, loop_pc, end_pc;
        int          n;
        void'($urandom(32'h3729));
        clk           = 1'b0;
        reset         = 1'b0;
        interrupt_i   = 1'b0;
        instruction_i = NOP_INST;
        pc_prev       = '0;
        ack_prev      = 1'b0;
        for (int i = 0; i < 256; i++) imem[i] = NOP_INST;
        for (int i = 0; i < NUM_REGS; i++) exp_reg[i] = '0;

        // Integer ops on random x1, x2
        for (int r = 1; r <= 2; r++) begin
            hi = 20'($urandom);
            lo = 12'($urandom);
            emit({hi, 5'(r), OPC_LUI});
            emit(enc_i(lo, 5'(r), F3_ADD_SUB, 5'(r), OPC_OP_IMM));
            exp_reg[r] = {{32{hi[19]}}, hi, 12'd0} + sext12(lo);
        end
        op_r(7'h00, F3_ADD_SUB, OPC_OP);
        op_r(7'h20, F3_ADD_SUB, OPC_OP);
        op_r(7'h00, F3_SLL, OPC_OP);
        op_r(7'h00, F3_SLT, OPC_OP);
        op_r(7'h00, F3_SLTU, OPC_OP);
        op_r(7'h00, F3_XOR, OPC_OP);
        op_r(7'h00, F3_SR, OPC_OP);
        op_r(7'h20, F3_SR, OPC_OP);
        op_r(7'h00, F3_OR, OPC_OP);
        op_r(7'h00, F3_AND, OPC_OP);
        op_i(12'($urandom), F3_ADD_SUB, OPC_OP_IMM);
        op_i(12'($urandom), F3_SLT, OPC_OP_IMM);
        op_i(12'($urandom), F3_SLTU, OPC_OP_IMM);
        op_i(12'($urandom), F3_XOR, OPC_OP_IMM);
        op_i(12'($urandom), F3_OR, OPC_OP_IMM);
        op_i(12'($urandom), F3_AND, OPC_OP_IMM);
        op_i({6'h00, 6'($urandom)}, F3_SLL, OPC_OP_IMM);
        op_i({6'h00, 6'($urandom)}, F3_SR, OPC_OP_IMM);
        op_i({6'h10, 6'($urandom)}, F3_SR, OPC_OP_IMM);   // SRAI
        op_r(7'h00, F3_ADD_SUB, OPC_OP_W);
        op_r(7'h20, F3_ADD_SUB, OPC_OP_W);
        op_r(7'h00, F3_SLL, OPC_OP_W);
        op_r(7'h00, F3_SR, OPC_OP_W);
        op_r(7'h20, F3_SR, OPC_OP_W);
        op_i(12'($urandom), F3_ADD_SUB, OPC_OP_IMM_W);
        op_i({7'h00, 5'($urandom)}, F3_SLL, OPC_OP_IMM_W);
        op_i({7'h00, 5'($urandom)}, F3_SR, OPC_OP_IMM_W);
        op_i({7'h20, 5'($urandom)}, F3_SR, OPC_OP_IMM_W);
        emit(enc_r(7'h00, 5'd2, 5'd1, F3_ADD_SUB, 5'd0, OPC_OP)); // x0 must stay zero
        section_end(cp_a);
        save_expected(0);

        // Branches, JAL and JALR
        bf = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int i = 0; i < 6; i++) begin
            branch(bf[i], 5'd2);
            branch(bf[i], 5'd1);
        end
        p = cur_pc();
        emit(enc_j(21'd8, 5'd5));
        exp_reg[5] = p + 64'd4;
        tgt[p] = p + 64'd8;
        emit(enc_i(12'd1, 5'd31, F3_ADD_SUB, 5'd31, OPC_OP_IMM));
        p = cur_pc();
        emit({20'd0, 5'd6, OPC_AUIPC});
        emit(enc_i(12'd12, 5'd6, 3'b000, 5'd7, OPC_JALR));
        exp_reg[6] = p;
        exp_reg[7] = p + 64'd8;
        tgt[p + 64'd4] = p + 64'd12;
        emit(enc_i(12'd1, 5'd31, F3_ADD_SUB, 5'd31, OPC_OP_IMM));
        section_end(cp_b);
        save_expected(1);

        // CSR access, old value to rd
        z1 = 5'($urandom) | 5'd1;
        z2 = 5'($urandom) | 5'd1;
        z3 = 5'($urandom) | 5'd1;
        emit(enc_i(CSR_MSCRATCH, 5'd1, F3_CSRRW, 5'd8, OPC_SYSTEM));
        exp_reg[8] = 64'd0;
        ms = exp_reg[1];
        emit(enc_i(CSR_MSCRATCH, 5'd2, F3_CSRRS, 5'd9, OPC_SYSTEM));
        exp_reg[9] = ms;
        ms = ms | exp_reg[2];
        emit(enc_i(CSR_MSCRATCH, 5'd1, F3_CSRRC, 5'd10, OPC_SYSTEM));
        exp_reg[10] = ms;
        ms = ms & ~exp_reg[1];
        emit(enc_i(CSR_MSCRATCH, 5'd0, F3_CSRRS, 5'd11, OPC_SYSTEM));
        exp_reg[11] = ms;
        emit(enc_i(CSR_MTVEC, z1, F3_CSRRWI, 5'd12, OPC_SYSTEM));
        exp_reg[12] = 64'd0;
        tv = {59'd0, z1};
        emit(enc_i(CSR_MTVEC, z2, F3_CSRRSI, 5'd13, OPC_SYSTEM));
        exp_reg[13] = tv;
        tv = tv | {59'd0, z2};
        emit(enc_i(CSR_MTVEC, z3, F3_CSRRCI, 5'd14, OPC_SYSTEM));
        exp_reg[14] = tv;
        tv = tv & ~{59'd0, z3};
        emit(enc_i(CSR_MTVEC, 5'd0, F3_CSRRS, 5'd15, OPC_SYSTEM));
        exp_reg[15] = tv;
        emit(enc_i(12'h7C0, 5'd0, F3_CSRRS, 5'd16, OPC_SYSTEM)); // Unmapped
        exp_reg[16] = 64'd0;
        section_end(cp_c);
        save_expected(2);

        // Interrupt loop, handler sits after the closing self-loop
        hnd_pc = cur_pc() + 64'd36;
        emit(enc_i(hnd_pc[11:0], 5'd0, F3_ADD_SUB, 5'd17, OPC_OP_IMM));
        emit(enc_i(CSR_MTVEC, 5'd17, F3_CSRRW, 5'd0, OPC_SYSTEM));
        emit(enc_i(12'(LOOP_N), 5'd0, F3_ADD_SUB, 5'd22, OPC_OP_IMM));
        emit(enc_i(12'd0, 5'd0, F3_ADD_SUB, 5'd18, OPC_OP_IMM));
        loop_pc = cur_pc();
        emit(enc_i(12'd1, 5'd18, F3_ADD_SUB, 5'd18, OPC_OP_IMM));
        emit(enc_b(13'h1FFC, 5'd22, 5'd18, F3_BLT));             // Back by 4
        emit(enc_i(CSR_MSTATUS, 5'd8, F3_CSRRCI, 5'd0, OPC_SYSTEM)); // mstatus.MIE off
        emit(NOP_INST);
        end_pc = cur_pc();
        emit(enc_j(21'd0, 5'd0));
        emit(enc_i(CSR_MEPC, 5'd0, F3_CSRRS, 5'd19, OPC_SYSTEM));
        emit(enc_i(CSR_MCAUSE, 5'd0, F3_CSRRS, 5'd20, OPC_SYSTEM));
        emit({MRET_FUNCT12, 13'd0, OPC_SYSTEM});
        exp_reg[17] = hnd_pc;
        exp_reg[18] = xlen_t'(LOOP_N);
        exp_reg[19] = loop_pc; // Interrupt lands while the first loop word sits in the IR
        exp_reg[20] = MCAUSE_MEXT_IRQ;
        exp_reg[22] = xlen_t'(LOOP_N);
        save_expected(3);
        limit = 4 * (wp + 2 * LOOP_N) + RESET_CYCLES + 40;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_reset();
        end
        reset = 1'b1;
        #1 check_reset();
        @(negedge clk);

        wait_pc(cp_a);
        check_regs(0);
        wait_pc(cp_b);
        check_regs(1);
        wait_pc(cp_c);
        check_regs(2);

        wait_pc(loop_pc + 64'd4);
        interrupt_i = 1'b1;
        n = 0;
        while (!interrupt_ack_o && n < 20) begin
            @(negedge clk);
            n++;
        end
        assert (interrupt_ack_o) else begin
            errors++;
            $display("Interrupt was never acknowledged");
        end
        check_value("pc_o", pc_o, hnd_pc);
        interrupt_i = 1'b0;
        wait_pc(hnd_pc + 64'd12);
        @(negedge clk);
        check_value("regs_o[19]", regs_o[19], loop_pc); // mepc copied by the handler
        check_value("pc_o", pc_o, loop_pc);             // MRET back to the saved mepc
        wait_pc(end_pc);
        check_regs(3);

        interrupt_i = 1'b1; // MIE is clear now
        repeat (20) begin
            @(negedge clk);
            assert (!interrupt_ack_o) else begin
                errors++;
                $display("Interrupt acknowledged while MIE was clear");
            end
        end
        interrupt_i = 1'b0;

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
